// File: hdl/dll_pkg.sv
package dll_pkg;

	////////////////////////////////////////////////////////////
	// Field widths

	localparam int hdr_w     = 8;
	localparam int data_w    = 12;
	localparam int payload_w = 24;

	// Credit fields inside a flow control DLLP payload
	localparam int fc_hdr_msb  = 21;
	localparam int fc_hdr_lsb  = 14;
	localparam int fc_data_msb = 11;

	////////////////////////////////////////////////////////////
	// Symbol codes and scrambler values

	localparam logic [7:0] k_sdp = 8'h5c;
	localparam logic [7:0] k_end = 8'hfd;
	localparam logic [7:0] k_com = 8'hbc;
	localparam logic [7:0] k_skp = 8'h1c;
	localparam logic [7:0] k_stp = 8'hfb;

	localparam logic [15:0] scrambler_seed      = 16'hffff;
	// LFSR state one step past the seed, loaded on a plain comma
	localparam logic [15:0] scrambler_after_com = 16'he817;

	////////////////////////////////////////////////////////////
	// Credits we advertise, zero means infinite

	localparam logic [hdr_w-1:0]  adv_hdr_p    = 8'd32;
	localparam logic [data_w-1:0] adv_data_p   = 12'd2047;
	localparam logic [hdr_w-1:0]  adv_hdr_np   = 8'd32;
	localparam logic [data_w-1:0] adv_data_np  = 12'd2047;
	localparam logic [hdr_w-1:0]  adv_hdr_cpl  = 8'd0;
	localparam logic [data_w-1:0] adv_data_cpl = 12'd0;

	////////////////////////////////////////////////////////////
	// Enumerations

	// DLLP types for VC0, low 3 bits are the VC number
	typedef enum logic [7:0] {
		dllp_ack         = 8'h00,
		dllp_nak         = 8'h10,
		dllp_initfc1_p   = 8'h40,
		dllp_initfc1_np  = 8'h50,
		dllp_initfc1_cpl = 8'h60,
		dllp_initfc2_p   = 8'hc0,
		dllp_initfc2_np  = 8'hd0,
		dllp_initfc2_cpl = 8'he0,
		dllp_updatefc_p  = 8'h80,
		dllp_updatefc_np = 8'h90,
		dllp_updatefc_cpl = 8'ha0
	} dllp_type_t;

	typedef enum logic [1:0] {
		rx_idle,
		rx_dllp_1,
		rx_dllp_2,
		rx_crc_end
	} rx_state_t;

	typedef enum logic [2:0] {
		tx_idle,
		tx_skip,
		tx_dllp_1,
		tx_dllp_2,
		tx_dllp_3
	} tx_state_t;

	typedef enum logic [1:0] {
		dl_inactive,
		dl_init,
		dl_active
	} dl_state_t;

	typedef enum logic [2:0] {
		fc_init1_p,
		fc_init1_np,
		fc_init1_cpl,
		fc_init2_p,
		fc_init2_np,
		fc_init2_cpl,
		fc_done
	} fc_step_t;

endpackage

// File: hdl/rx_descrambler.sv
`timescale 1ns/1ps

module rx_descrambler import dll_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,

	// Lane word from the SERDES
	input  logic [15:0] rx_data,
	input  logic [1:0]  rx_charisk,
	input  logic [1:0]  rx_err,

	// Registered, descrambled word
	output logic [15:0] rx_word,
	output logic [1:0]  rx_k,
	output logic        rx_symbol_err
);

	logic [15:0] lfsr;
	logic [15:0] lfsr_next;
	logic [15:0] scr_out;
	logic        com_lane0;
	logic        skp_lane1;
	logic        skp_pair;

	////////////////////////////////////////////////////////////
	// LFSR, 16 steps per clock

	// Output bit is the MSB, feedback taps folded in as XOR 1Ch
	always_comb begin
		lfsr_next = lfsr;
		scr_out   = '0;
		for (int i = 0; i < 16; i++) begin
			scr_out[i] = lfsr_next[15];
			if (scr_out[i])
				lfsr_next = ((lfsr_next ^ 16'h001c) << 1) | 16'h0001;
			else
				lfsr_next = lfsr_next << 1;
		end
	end

	// Ordered set decode on the raw lane
	assign com_lane0 = rx_charisk[0] && (rx_data[7:0] == k_com);
	assign skp_lane1 = rx_charisk[1] && (rx_data[15:8] == k_skp);
	assign skp_pair  = (rx_charisk == 2'b11) && (rx_data == {k_skp, k_skp});

	////////////////////////////////////////////////////////////
	// Descramble and register

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lfsr          <= scrambler_seed;
			rx_word       <= '0;
			rx_k          <= '0;
			rx_symbol_err <= 1'b0;
		end else begin
			rx_k          <= rx_charisk;
			rx_symbol_err <= |rx_err;

			// K symbols bypass the scrambler, data bytes do not
			rx_word[7:0]  <= rx_charisk[0] ? rx_data[7:0] : rx_data[7:0] ^ scr_out[7:0];
			rx_word[15:8] <= rx_charisk[1] ? rx_data[15:8] : rx_data[15:8] ^ scr_out[15:8];

			// A comma resyncs the sequence
			if (com_lane0)
				lfsr <= skp_lane1 ? scrambler_seed : scrambler_after_com;
			// Skips do not advance the LFSR
			else if (!skp_pair)
				lfsr <= lfsr_next;
		end
	end

endmodule

// File: hdl/dllp_crc16.sv
`timescale 1ns/1ps

module dllp_crc16 import dll_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        first_phase,
	input  logic        second_phase,
	input  logic [15:0] data_first,
	input  logic [15:0] data_second,
	output logic [15:0] crc
);

	logic [15:0] crc_state;

	// Two bytes per step, low byte first, each byte LSB first
	function automatic logic [15:0] crc_step(input logic [15:0] c, input logic [15:0] d);
		logic [15:0] r;
		logic        fb;
		r = c;
		for (int i = 0; i < 16; i++) begin
			fb = r[15] ^ d[i];
			r  = r << 1;
			if (fb)
				r = r ^ 16'h100b;
		end
		return r;
	endfunction

	// Phase 1 starts from the seed, phase 2 continues from it
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			crc_state <= scrambler_seed;
		else if (first_phase)
			crc_state <= crc_step(16'hffff, data_first);
		else if (second_phase)
			crc_state <= crc_step(crc_state, data_second);
	end

	// Complemented, bits reversed within each byte
	always_comb begin
		for (int i = 0; i < 8; i++) begin
			crc[15 - i] = ~crc_state[8 + i];
			crc[7 - i]  = ~crc_state[i];
		end
	end

endmodule

// File: hdl/dllp_receiver.sv
`timescale 1ns/1ps

module dllp_receiver import dll_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 link_up,
	input  logic [15:0]          rx_word,
	input  logic [1:0]           rx_k,
	input  logic                 rx_symbol_err,
	output logic                 dllp_valid,
	output dllp_type_t           dllp_type,
	output logic [payload_w-1:0] dllp_payload
);

	rx_state_t   rx_state;
	logic [7:0]  crc_hi;
	logic [15:0] crc_calc;
	logic        sdp_start;
	logic        abort;

	// SDP must sit alone in lane 0
	assign sdp_start = (rx_k == 2'b01) && (rx_word[7:0] == k_sdp);

	// Errors, link loss and TLP starts drop the frame
	assign abort = rx_symbol_err || !link_up || (rx_k[0] && rx_word[7:0] == k_stp);

	////////////////////////////////////////////////////////////
	// CRC over type and payload

	dllp_crc16 crc_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.first_phase  (rx_state == rx_dllp_1),
		.second_phase (rx_state == rx_dllp_2),
		.data_first   ({rx_word[7:0], dllp_type}),
		.data_second  ({rx_word[7:0], dllp_payload[15:8]}),
		.crc          (crc_calc)
	);

	////////////////////////////////////////////////////////////
	// Framing FSM

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_state   <= rx_idle;
			dllp_valid <= 1'b0;
		end else begin
			dllp_valid <= 1'b0;
			case (rx_state)
				rx_idle: begin
					if (sdp_start)
						rx_state <= rx_dllp_1;
				end
				// Payload bytes 2 and 1
				rx_dllp_1: begin
					rx_state <= (rx_k == 2'b00) ? rx_dllp_2 : rx_idle;
				end
				// Payload byte 0 and CRC high
				rx_dllp_2: begin
					rx_state <= (rx_k == 2'b00) ? rx_crc_end : rx_idle;
				end
				// CRC low with END in lane 1
				rx_crc_end: begin
					if ((rx_k == 2'b10) && (rx_word[15:8] == k_end)
						&& (crc_calc == {crc_hi, rx_word[7:0]}))
						dllp_valid <= 1'b1;
					rx_state <= rx_idle;
				end
				default: rx_state <= rx_idle;
			endcase
			if (abort)
				rx_state <= rx_idle;
		end
	end

	// Frame contents, held until the next SDP
	always_ff @(posedge clk) begin
		if (rx_state == rx_idle && sdp_start)
			dllp_type <= dllp_type_t'(rx_word[15:8]);
		if (rx_state == rx_dllp_1)
			dllp_payload[23:8] <= {rx_word[7:0], rx_word[15:8]};
		if (rx_state == rx_dllp_2) begin
			dllp_payload[7:0] <= rx_word[7:0];
			crc_hi            <= rx_word[15:8];
		end
	end

endmodule

// File: hdl/partner_credit_store.sv
`timescale 1ns/1ps

module partner_credit_store import dll_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 dllp_valid,
	input  dllp_type_t           dllp_type,
	input  logic [payload_w-1:0] dllp_payload,
	input  logic                 clear_fi2,
	input  logic                 link_active,
	output logic                 credits_seen,
	output logic                 fi2_seen,
	output logic [hdr_w-1:0]     hdr_p,
	output logic [data_w-1:0]    data_p,
	output logic [hdr_w-1:0]     hdr_np,
	output logic [data_w-1:0]    data_np,
	output logic [hdr_w-1:0]     hdr_cpl,
	output logic [data_w-1:0]    data_cpl
);

	logic seen_p;
	logic seen_np;
	logic seen_cpl;

	assign credits_seen = seen_p && seen_np && seen_cpl;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			{seen_p, seen_np, seen_cpl} <= '0;
			fi2_seen <= 1'b0;
			{hdr_p, data_p, hdr_np, data_np, hdr_cpl, data_cpl} <= '0;
		end else begin
			if (clear_fi2 || !link_active)
				fi2_seen <= 1'b0;
			if (dllp_valid) begin
				case (dllp_type)
					// Only the first InitFC1 of each class is taken
					dllp_initfc1_p: begin
						if (!seen_p) begin
							seen_p <= 1'b1;
							hdr_p  <= dllp_payload[fc_hdr_msb:fc_hdr_lsb];
							data_p <= dllp_payload[fc_data_msb:0];
						end
					end
					dllp_initfc1_np: begin
						if (!seen_np) begin
							seen_np <= 1'b1;
							hdr_np  <= dllp_payload[fc_hdr_msb:fc_hdr_lsb];
							data_np <= dllp_payload[fc_data_msb:0];
						end
					end
					dllp_initfc1_cpl: begin
						if (!seen_cpl) begin
							seen_cpl <= 1'b1;
							hdr_cpl  <= dllp_payload[fc_hdr_msb:fc_hdr_lsb];
							data_cpl <= dllp_payload[fc_data_msb:0];
						end
					end
					// Partner reached FI2, overrides a clear in the same cycle
					dllp_initfc2_p, dllp_initfc2_np, dllp_initfc2_cpl,
					dllp_updatefc_p, dllp_updatefc_np, dllp_updatefc_cpl:
						fi2_seen <= 1'b1;
					default: ;
				endcase
			end
		end
	end

endmodule

// File: hdl/dllp_transmitter.sv
`timescale 1ns/1ps

module dllp_transmitter import dll_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n,

	// DLLP request from the FC controller
	input  logic                 tx_req,
	input  dllp_type_t           tx_type,
	input  logic [payload_w-1:0] tx_payload,
	output logic                 tx_ack,

	// Skip window
	input  logic                 tx_skip_req,
	output logic                 tx_skip_ack,
	input  logic                 tx_skip_done,

	// Lane word to the SERDES
	output logic [15:0]          tx_data,
	output logic [1:0]           tx_charisk
);

	tx_state_t   tx_state;
	logic [15:0] crc;
	logic        start;

	// Skip wins over a waiting DLLP
	assign start = (tx_state == tx_idle) && tx_req && !tx_skip_req;

	// CRC starts as the SDP word goes out, ready for word 3
	dllp_crc16 crc_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.first_phase  (start),
		.second_phase (tx_state == tx_dllp_1),
		.data_first   ({tx_payload[23:16], tx_type}),
		.data_second  ({tx_payload[7:0], tx_payload[15:8]}),
		.crc          (crc)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tx_state    <= tx_idle;
			tx_data     <= '0;
			tx_charisk  <= '0;
			tx_ack      <= 1'b0;
			tx_skip_ack <= 1'b0;
		end else begin
			tx_ack      <= 1'b0;
			tx_skip_ack <= 1'b0;
			case (tx_state)
				// Logical idle is all zero data
				tx_idle: begin
					tx_data    <= '0;
					tx_charisk <= '0;
					if (tx_skip_req) begin
						tx_skip_ack <= 1'b1;
						tx_state    <= tx_skip;
					end else if (tx_req) begin
						tx_data    <= {tx_type, k_sdp};
						tx_charisk <= 2'b01;
						tx_state   <= tx_dllp_1;
					end
				end
				// Lane is owned by the skip generator
				tx_skip: begin
					if (tx_skip_done)
						tx_state <= tx_idle;
				end
				tx_dllp_1: begin
					tx_data    <= {tx_payload[15:8], tx_payload[23:16]};
					tx_charisk <= 2'b00;
					tx_state   <= tx_dllp_2;
				end
				// Request is released on this word
				tx_dllp_2: begin
					tx_data    <= {crc[15:8], tx_payload[7:0]};
					tx_charisk <= 2'b00;
					tx_ack     <= 1'b1;
					tx_state   <= tx_dllp_3;
				end
				tx_dllp_3: begin
					tx_data    <= {k_end, crc[7:0]};
					tx_charisk <= 2'b10;
					tx_state   <= tx_idle;
				end
				default: tx_state <= tx_idle;
			endcase
		end
	end

endmodule

// File: hdl/fc_init_control.sv
`timescale 1ns/1ps

module fc_init_control import dll_pkg::*; #(
	parameter int fc_update_interval = 3249
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 link_up,
	input  logic [15:0]          rx_word,
	input  logic [1:0]           rx_k,
	input  logic                 rx_symbol_err,
	input  logic                 credits_seen,
	input  logic                 fi2_seen,
	output logic                 clear_fi2,
	output logic                 tx_req,
	output dllp_type_t           tx_type,
	output logic [payload_w-1:0] tx_payload,
	input  logic                 tx_ack,
	output logic                 dl_link_up
);

	// Extra bit so the timer can run past the limit while a DLLP is pending
	localparam int timer_w = $clog2(fc_update_interval + 1) + 1;
	localparam logic [timer_w-1:0] timer_max = timer_w'(fc_update_interval);

	function automatic logic [payload_w-1:0] fc_payload(input logic [hdr_w-1:0] hdr,
		input logic [data_w-1:0] data);
		logic [payload_w-1:0] p;
		p = '0;
		p[fc_hdr_msb:fc_hdr_lsb] = hdr;
		p[fc_data_msb:0] = data;
		return p;
	endfunction

	localparam logic [payload_w-1:0] payload_p   = fc_payload(adv_hdr_p, adv_data_p);
	localparam logic [payload_w-1:0] payload_np  = fc_payload(adv_hdr_np, adv_data_np);
	localparam logic [payload_w-1:0] payload_cpl = fc_payload(adv_hdr_cpl, adv_data_cpl);

	dl_state_t          dl_state;
	fc_step_t           fc_step;
	logic               upd_np;
	logic [2:0]         idle_count;
	logic [timer_w-1:0] fc_timer;
	logic               rx_idle_word;

	assign rx_idle_word = (rx_word == 16'h0000) && (rx_k == 2'b00) && !rx_symbol_err;

	////////////////////////////////////////////////////////////
	// DLLP selected by the current step

	// Only changes after an ack, so stable while tx_req is high
	always_comb begin
		tx_type    = dllp_updatefc_p;
		tx_payload = payload_p;
		case (fc_step)
			fc_init1_p:   tx_type = dllp_initfc1_p;
			fc_init1_np: begin
				tx_type    = dllp_initfc1_np;
				tx_payload = payload_np;
			end
			fc_init1_cpl: begin
				tx_type    = dllp_initfc1_cpl;
				tx_payload = payload_cpl;
			end
			fc_init2_p:   tx_type = dllp_initfc2_p;
			fc_init2_np: begin
				tx_type    = dllp_initfc2_np;
				tx_payload = payload_np;
			end
			fc_init2_cpl: begin
				tx_type    = dllp_initfc2_cpl;
				tx_payload = payload_cpl;
			end
			// Completions are infinite, no UpdateFC-Cpl
			default: begin
				if (upd_np) begin
					tx_type    = dllp_updatefc_np;
					tx_payload = payload_np;
				end
			end
		endcase
	end

	////////////////////////////////////////////////////////////
	// Link state FSM

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dl_state   <= dl_inactive;
			fc_step    <= fc_init1_p;
			upd_np     <= 1'b0;
			idle_count <= '0;
			fc_timer   <= '0;
			tx_req     <= 1'b0;
			clear_fi2  <= 1'b0;
			dl_link_up <= 1'b0;
		end else begin
			clear_fi2 <= 1'b0;
			case (dl_state)
				// Wait for 8 idle words in a row
				dl_inactive: begin
					tx_req     <= 1'b0;
					dl_link_up <= 1'b0;
					fc_step    <= fc_init1_p;
					if (link_up && rx_idle_word) begin
						idle_count <= idle_count + 3'd1;
						if (idle_count == 3'd7) begin
							dl_state <= dl_init;
							tx_req   <= 1'b1;
						end
					end else
						idle_count <= '0;
				end
				// Step through the InitFC DLLPs, one per ack
				dl_init: begin
					if (tx_ack) begin
						case (fc_step)
							fc_init1_p:  fc_step <= fc_init1_np;
							fc_init1_np: fc_step <= fc_init1_cpl;
							fc_init1_cpl: begin
								if (credits_seen) begin
									fc_step   <= fc_init2_p;
									clear_fi2 <= 1'b1;
								end else
									fc_step <= fc_init1_p;
							end
							fc_init2_p:  fc_step <= fc_init2_np;
							fc_init2_np: fc_step <= fc_init2_cpl;
							fc_init2_cpl: begin
								if (fi2_seen) begin
									fc_step    <= fc_done;
									dl_state   <= dl_active;
									dl_link_up <= 1'b1;
									tx_req     <= 1'b0;
									upd_np     <= 1'b0;
									fc_timer   <= '0;
								end else
									fc_step <= fc_init2_p;
							end
							default: fc_step <= fc_init1_p;
						endcase
					end
				end
				// Periodic UpdateFC-P, NP chained right behind it
				dl_active: begin
					fc_timer <= fc_timer + timer_w'(1);
					if (tx_ack) begin
						upd_np <= !upd_np;
						tx_req <= !upd_np;
					end else if (!tx_req && (fc_timer >= timer_max)) begin
						tx_req   <= 1'b1;
						fc_timer <= '0;
					end
				end
				default: dl_state <= dl_inactive;
			endcase

			// Link loss drops straight back to inactive
			if ((dl_state != dl_inactive) && !link_up) begin
				dl_state   <= dl_inactive;
				dl_link_up <= 1'b0;
				tx_req     <= 1'b0;
				idle_count <= '0;
			end
		end
	end

endmodule

// File: hdl/pcie_data_link.sv
`timescale 1ns/1ps

module pcie_data_link #(
	parameter int fc_update_interval = 3249
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        link_up,

	// Lane from the SERDES
	input  logic [15:0] rx_data,
	input  logic [1:0]  rx_charisk,
	input  logic [1:0]  rx_err,

	// Lane to the SERDES
	output logic [15:0] tx_data,
	output logic [1:0]  tx_charisk,

	// Skip window
	input  logic        tx_skip_req,
	output logic        tx_skip_ack,
	input  logic        tx_skip_done,

	output logic        dl_link_up,

	// Partner credits from InitFC1
	output logic [7:0]  hdr_p,
	output logic [11:0] data_p,
	output logic [7:0]  hdr_np,
	output logic [11:0] data_np,
	output logic [7:0]  hdr_cpl,
	output logic [11:0] data_cpl
);

	logic [15:0]          rx_word;
	logic [1:0]           rx_k;
	logic                 rx_symbol_err;
	logic                 dllp_valid;
	dll_pkg::dllp_type_t  dllp_type;
	logic [23:0]          dllp_payload;
	logic                 credits_seen;
	logic                 fi2_seen;
	logic                 clear_fi2;
	logic                 tx_req;
	dll_pkg::dllp_type_t  tx_type;
	logic [23:0]          tx_payload;
	logic                 tx_ack;

	////////////////////////////////////////////////////////////
	// Receive side

	rx_descrambler rx_descrambler_inst (
		.clk           (clk),
		.rst_n         (rst_n),
		.rx_data       (rx_data),
		.rx_charisk    (rx_charisk),
		.rx_err        (rx_err),
		.rx_word       (rx_word),
		.rx_k          (rx_k),
		.rx_symbol_err (rx_symbol_err)
	);

	dllp_receiver dllp_receiver_inst (
		.clk           (clk),
		.rst_n         (rst_n),
		.link_up       (link_up),
		.rx_word       (rx_word),
		.rx_k          (rx_k),
		.rx_symbol_err (rx_symbol_err),
		.dllp_valid    (dllp_valid),
		.dllp_type     (dllp_type),
		.dllp_payload  (dllp_payload)
	);

	partner_credit_store partner_credit_store_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.dllp_valid   (dllp_valid),
		.dllp_type    (dllp_type),
		.dllp_payload (dllp_payload),
		.clear_fi2    (clear_fi2),
		.link_active  (link_up),
		.credits_seen (credits_seen),
		.fi2_seen     (fi2_seen),
		.hdr_p        (hdr_p),
		.data_p       (data_p),
		.hdr_np       (hdr_np),
		.data_np      (data_np),
		.hdr_cpl      (hdr_cpl),
		.data_cpl     (data_cpl)
	);

	////////////////////////////////////////////////////////////
	// Flow control and transmit side

	fc_init_control #(
		.fc_update_interval (fc_update_interval)
	) fc_init_control_inst (
		.clk           (clk),
		.rst_n         (rst_n),
		.link_up       (link_up),
		.rx_word       (rx_word),
		.rx_k          (rx_k),
		.rx_symbol_err (rx_symbol_err),
		.credits_seen  (credits_seen),
		.fi2_seen      (fi2_seen),
		.clear_fi2     (clear_fi2),
		.tx_req        (tx_req),
		.tx_type       (tx_type),
		.tx_payload    (tx_payload),
		.tx_ack        (tx_ack),
		.dl_link_up    (dl_link_up)
	);

	dllp_transmitter dllp_transmitter_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.tx_req       (tx_req),
		.tx_type      (tx_type),
		.tx_payload   (tx_payload),
		.tx_ack       (tx_ack),
		.tx_skip_req  (tx_skip_req),
		.tx_skip_ack  (tx_skip_ack),
		.tx_skip_done (tx_skip_done),
		.tx_data      (tx_data),
		.tx_charisk   (tx_charisk)
	);

endmodule

// File: testbench/tb_pcie_data_link.sv
`timescale 1ns/1ps

module tb_pcie_data_link import dll_pkg::*; ();

	localparam int interval   = 63;
	localparam int num_rows   = 6;
	localparam int row_words  = 8;
	localparam int watchdog_cycles = 20 * (num_rows * row_words + interval);

	logic        clk;
	logic        rst_n;
	logic        link_up;
	logic [15:0] rx_data;
	logic [1:0]  rx_charisk;
	logic [1:0]  rx_err;
	logic [15:0] tx_data;
	logic [1:0]  tx_charisk;
	logic        tx_skip_req;
	logic        tx_skip_ack;
	logic        tx_skip_done;
	logic        dl_link_up;
	logic [7:0]  hdr_p;
	logic [11:0] data_p;
	logic [7:0]  hdr_np;
	logic [11:0] data_np;
	logic [7:0]  hdr_cpl;
	logic [11:0] data_cpl;

	// Lane scrambler state on the sending side
	logic [15:0] tb_lfsr;
	int          cycle;
	int          error_count;
	int          test_count;
	int          test_fail_count;
	int          test_start_errors;

	// Frames seen on tx_data
	logic [7:0]  frame_type_q[$];
	logic [23:0] frame_payload_q[$];
	int          frame_cycle_q[$];
	logic [15:0] mon_w[4];
	int          mon_idx;
	int          mon_start;

	////////////////////////////////////////////////////////////
	// Stimulus table: received InitFC1 DLLPs and expected credits

	logic [7:0]  row_type [num_rows] = '{8'h40, 8'h40, 8'h50, 8'h50, 8'h60, 8'h60};
	logic [7:0]  row_hdr  [num_rows] = '{8'd10, 8'd20, 8'd7, 8'd7, 8'd5, 8'd3};
	logic [11:0] row_data [num_rows] = '{12'd100, 12'd200, 12'd300, 12'd300, 12'd50, 12'd40};
	logic        row_bad  [num_rows] = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0};
	logic [7:0]  exp_hdr_p    [num_rows] = '{8'd10, 8'd10, 8'd10, 8'd10, 8'd10, 8'd10};
	logic [11:0] exp_data_p   [num_rows] = '{12'd100, 12'd100, 12'd100, 12'd100, 12'd100, 12'd100};
	logic [7:0]  exp_hdr_np   [num_rows] = '{8'd0, 8'd0, 8'd0, 8'd7, 8'd7, 8'd7};
	logic [11:0] exp_data_np  [num_rows] = '{12'd0, 12'd0, 12'd0, 12'd300, 12'd300, 12'd300};
	logic [7:0]  exp_hdr_cpl  [num_rows] = '{8'd0, 8'd0, 8'd0, 8'd0, 8'd0, 8'd3};
	logic [11:0] exp_data_cpl [num_rows] = '{12'd0, 12'd0, 12'd0, 12'd0, 12'd0, 12'd40};

	pcie_data_link #(
		.fc_update_interval (interval)
	) pcie_data_link_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.link_up      (link_up),
		.rx_data      (rx_data),
		.rx_charisk   (rx_charisk),
		.rx_err       (rx_err),
		.tx_data      (tx_data),
		.tx_charisk   (tx_charisk),
		.tx_skip_req  (tx_skip_req),
		.tx_skip_ack  (tx_skip_ack),
		.tx_skip_done (tx_skip_done),
		.dl_link_up   (dl_link_up),
		.hdr_p        (hdr_p),
		.data_p       (data_p),
		.hdr_np       (hdr_np),
		.data_np      (data_np),
		.hdr_cpl      (hdr_cpl),
		.data_cpl     (data_cpl)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk)
		cycle <= cycle + 1;

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("Watchdog expired, the run took longer than its tests allow");
		$display("Testbench failed");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Reference models

	// Header credit in bits 21..14, data credit in 11..0
	function automatic logic [23:0] fc_payload(input logic [7:0] hdr, input logic [11:0] data);
		return {2'b00, hdr, 2'b00, data};
	endfunction

	// CRC-16 poly 100Bh, seed FFFFh, bytes LSB first, type byte first
	function automatic logic [15:0] dllp_crc(input logic [7:0] t, input logic [23:0] p);
		logic [31:0] bytes;
		logic [15:0] c;
		logic [15:0] r;
		logic        fb;
		bytes = {p[7:0], p[15:8], p[23:16], t};
		c = 16'hffff;
		for (int i = 0; i < 32; i++) begin
			fb = c[15] ^ bytes[i];
			c  = c << 1;
			if (fb)
				c = c ^ 16'h100b;
		end
		for (int i = 0; i < 8; i++) begin
			r[15 - i] = ~c[8 + i];
			r[7 - i]  = ~c[i];
		end
		return r;
	endfunction

	// Scrambler step, returns next state over the 16 output bits
	function automatic logic [31:0] lfsr_advance(input logic [15:0] s);
		logic [15:0] o;
		for (int i = 0; i < 16; i++) begin
			o[i] = s[15];
			if (o[i])
				s = ((s ^ 16'h001c) << 1) | 16'h0001;
			else
				s = s << 1;
		end
		return {s, o};
	endfunction

	////////////////////////////////////////////////////////////
	// Checks and stimulus tasks

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			error_count++;
			$display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic report_failure(input string what);
		error_count++;
		$display("Failure at %0t ns: %s", $time, what);
	endtask

	task automatic begin_test();
		test_start_errors = error_count;
	endtask

	task automatic end_test(input string name);
		test_count++;
		if (error_count != test_start_errors)
			test_fail_count++;
		$display("Test %0d %s: %s", test_count, name,
			(error_count == test_start_errors) ? "ok" : "FAILED");
	endtask

	// One lane word, scrambled unless K
	task automatic send_word(input logic [15:0] d, input logic [1:0] k);
		logic [31:0] adv;
		@(negedge clk);
		adv = lfsr_advance(tb_lfsr);
		rx_charisk    = k;
		rx_data[7:0]  = k[0] ? d[7:0] : d[7:0] ^ adv[7:0];
		rx_data[15:8] = k[1] ? d[15:8] : d[15:8] ^ adv[15:8];
		if (k[0] && d[7:0] == k_com)
			tb_lfsr = scrambler_after_com;
		else
			tb_lfsr = adv[31:16];
	endtask

	task automatic send_idles(input int n);
		for (int i = 0; i < n; i++)
			send_word(16'h0000, 2'b00);
	endtask

	task automatic send_dllp(input logic [7:0] t, input logic [23:0] p, input logic bad);
		logic [15:0] c;
		c = dllp_crc(t, p);
		if (bad)
			c[7:0] = ~c[7:0];
		send_word({t, k_sdp}, 2'b01);
		send_word({p[15:8], p[23:16]}, 2'b00);
		send_word({c[15:8], p[7:0]}, 2'b00);
		send_word({k_end, c[7:0]}, 2'b10);
	endtask

	task automatic wait_frames(input int n);
		int waited;
		waited = 0;
		while (frame_type_q.size() < n && waited < 100) begin
			send_idles(1);
			waited++;
		end
		if (frame_type_q.size() < n)
			report_failure("expected DLLP frames never appeared on tx_data");
	endtask

	////////////////////////////////////////////////////////////
	// Frame monitor on the transmit lane

	always @(negedge clk) begin
		if (rst_n) begin
			if (mon_idx == 0) begin
				if (tx_charisk == 2'b01 && tx_data[7:0] == k_sdp) begin
					mon_w[0]  = tx_data;
					mon_start = cycle;
					mon_idx   = 1;
				end
			end else begin
				mon_w[mon_idx] = tx_data;
				if (mon_idx == 3) begin
					check("tx_charisk end", 32'(tx_charisk), 32'h2);
					check("tx end symbol", 32'(tx_data[15:8]), 32'(k_end));
					frame_type_q.push_back(mon_w[0][15:8]);
					frame_payload_q.push_back({mon_w[1][7:0], mon_w[1][15:8], mon_w[2][7:0]});
					frame_cycle_q.push_back(mon_start);
					check("tx crc", 32'({mon_w[2][15:8], mon_w[3][7:0]}),
						32'(dllp_crc(mon_w[0][15:8],
						{mon_w[1][7:0], mon_w[1][15:8], mon_w[2][7:0]})));
					mon_idx = 0;
				end else begin
					check("tx_charisk body", 32'(tx_charisk), 32'h0);
					mon_idx++;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		int base;
		int found;
		int link_cycle;
		int last_p;
		int p_count;
		int acks;
		int waited;
		rst_n = 1'b0;
		link_up = 1'b0;
		rx_data = 16'h0000;
		rx_charisk = 2'b00;
		rx_err = 2'b00;
		tx_skip_req = 1'b0;
		tx_skip_done = 1'b0;
		tb_lfsr = scrambler_seed;
		error_count = 0;
		test_count = 0;
		test_fail_count = 0;
		mon_idx = 0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		begin_test();
		check("tx_data", 32'(tx_data), 32'h0);
		check("tx_charisk", 32'(tx_charisk), 32'h0);
		check("tx_skip_ack", 32'(tx_skip_ack), 32'h0);
		check("dl_link_up", 32'(dl_link_up), 32'h0);
		end_test("reset values");

		// Comma resyncs the partner scrambler, then logical idle
		begin_test();
		link_up = 1'b1;
		send_word({8'h00, k_com}, 2'b01);
		wait_frames(3);
		check("initfc1 p type", 32'(frame_type_q[0]), 32'h40);
		check("initfc1 p payload", 32'(frame_payload_q[0]), 32'(fc_payload(adv_hdr_p, adv_data_p)));
		check("initfc1 np type", 32'(frame_type_q[1]), 32'h50);
		check("initfc1 np payload", 32'(frame_payload_q[1]),
			32'(fc_payload(adv_hdr_np, adv_data_np)));
		check("initfc1 cpl type", 32'(frame_type_q[2]), 32'h60);
		check("initfc1 cpl payload", 32'(frame_payload_q[2]),
			32'(fc_payload(adv_hdr_cpl, adv_data_cpl)));
		end_test("InitFC1 sequence");

		begin_test();
		base = frame_type_q.size();
		for (int i = 0; i < num_rows; i++) begin
			send_dllp(row_type[i], fc_payload(row_hdr[i], row_data[i]), row_bad[i]);
			send_idles(4);
			check("hdr_p", 32'(hdr_p), 32'(exp_hdr_p[i]));
			check("data_p", 32'(data_p), 32'(exp_data_p[i]));
			check("hdr_np", 32'(hdr_np), 32'(exp_hdr_np[i]));
			check("data_np", 32'(data_np), 32'(exp_data_np[i]));
			check("hdr_cpl", 32'(hdr_cpl), 32'(exp_hdr_cpl[i]));
			check("data_cpl", 32'(data_cpl), 32'(exp_data_cpl[i]));
		end
		end_test("partner credit table");

		// Partner credits complete, InitFC2 must follow
		begin_test();
		found = -1;
		waited = 0;
		while (found < 0 && waited < 100) begin
			for (int i = base; i < frame_type_q.size(); i++)
				if (found < 0 && frame_type_q[i] == 8'hc0)
					found = i;
			send_idles(1);
			waited++;
		end
		if (found < 0)
			report_failure("no InitFC2-P frame after all credits were received");
		else
			check("initfc2 p payload", 32'(frame_payload_q[found]),
				32'(fc_payload(adv_hdr_p, adv_data_p)));
		send_dllp(8'hc0, fc_payload(8'd10, 12'd100), 1'b0);
		waited = 0;
		while (!dl_link_up && waited < 100) begin
			send_idles(1);
			waited++;
		end
		if (!dl_link_up)
			report_failure("dl_link_up did not rise after InitFC2 was received");
		link_cycle = cycle;
		base = frame_type_q.size();
		send_idles(3 * (interval + 8));
		last_p = link_cycle;
		p_count = 0;
		for (int i = base; i < frame_type_q.size(); i++) begin
			if (frame_type_q[i] == 8'h80) begin
				check("updatefc p payload", 32'(frame_payload_q[i]),
					32'(fc_payload(adv_hdr_p, adv_data_p)));
				if (frame_cycle_q[i] - last_p > interval + 8)
					report_failure("UpdateFC-P came later than the update interval allows");
				if (i + 1 < frame_type_q.size())
					check("updatefc np type", 32'(frame_type_q[i + 1]), 32'h90);
				last_p = frame_cycle_q[i];
				p_count++;
			end
		end
		if (p_count < 2)
			report_failure("fewer than two UpdateFC-P frames in three intervals");
		end_test("InitFC2 and UpdateFC");

		// Skip window holds the lane at zero
		begin_test();
		tx_skip_req = 1'b1;
		acks = 0;
		waited = 0;
		while (acks == 0 && waited < 20) begin
			send_idles(1);
			if (tx_skip_ack)
				acks++;
			waited++;
		end
		tx_skip_req = 1'b0;
		if (acks == 0)
			report_failure("tx_skip_ack never pulsed");
		base = frame_type_q.size();
		for (int i = 0; i < interval + 8; i++) begin
			send_idles(1);
			check("tx_data in skip", 32'(tx_data), 32'h0);
			check("tx_charisk in skip", 32'(tx_charisk), 32'h0);
			if (tx_skip_ack)
				acks++;
		end
		tx_skip_done = 1'b1;
		send_idles(1);
		tx_skip_done = 1'b0;
		check("tx_skip_ack pulses", 32'(acks), 32'd1);
		check("frames in skip", 32'(frame_type_q.size() - base), 32'd0);
		end_test("skip window");

		// Link drop and a fresh InitFC1 round
		begin_test();
		link_up = 1'b0;
		send_idles(3);
		check("dl_link_up", 32'(dl_link_up), 32'h0);
		send_idles(6);
		base = frame_type_q.size();
		link_up = 1'b1;
		wait_frames(base + 3);
		if (frame_type_q.size() >= base + 3) begin
			check("relink p type", 32'(frame_type_q[base]), 32'h40);
			check("relink np type", 32'(frame_type_q[base + 1]), 32'h50);
			check("relink cpl type", 32'(frame_type_q[base + 2]), 32'h60);
		end
		end_test("link drop and retrain");

		$display("%0d tests, %0d failed, %0d errors", test_count, test_fail_count, error_count);
		if (error_count == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// File: filelist.f
hdl/dll_pkg.sv
hdl/rx_descrambler.sv
hdl/dllp_crc16.sv
hdl/dllp_receiver.sv
hdl/partner_credit_store.sv
hdl/dllp_transmitter.sv
hdl/fc_init_control.sv
hdl/pcie_data_link.sv
testbench/tb_pcie_data_link.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_pcie_data_link \
	-f filelist.f --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Testbench failed" sim.log; then
	exit 1
fi
exit 0
